// ==== Bender.yml ====
package:
  name: lvda

sources:
  - verilog/lvda_pkg.sv
  - verilog/lvda_timing.sv
  - verilog/lvda_cmd_decode.sv
  - verilog/lvda_discrete_sampler.sv
  - verilog/lvda_countdown.sv
  - verilog/lvda.sv
  - target: test
    files:
      - tests/lvda_tb.sv

// ==== build.f ====
verilog/lvda_pkg.sv
verilog/lvda_timing.sv
verilog/lvda_cmd_decode.sv
verilog/lvda_discrete_sampler.sv
verilog/lvda_countdown.sv
verilog/lvda.sv
tests/lvda_tb.sv

// ==== tests/lvda_tb.sv ====
`default_nettype none

module lvda_tb;

    localparam int WORD_CYCLES = lvda_pkg::WORD_BITS * 4;
    localparam int MAX_ENTRIES = 32;

    typedef enum logic [2:0] {
        OP_READ,
        OP_RAND_READ,
        OP_PAIR,      // Read with a second read held behind it
        OP_LOAD,
        OP_CLEAR,
        OP_OTHER      // Unknown address
    } op_e;

    logic                     sim_clk;
    logic                     rst_n;
    logic                     cmd_valid;
    logic                     cmd_ready;
    lvda_pkg::lvda_addr_t     cmd_addr;
    lvda_pkg::lvda_word_t     cmd_data;
    lvda_pkg::lvda_discrete_t discrete;
    logic                     data_out;
    logic                     data_frame;
    logic                     intc;

    op_e                  op_tab   [MAX_ENTRIES];
    lvda_pkg::lvda_addr_t addr_tab [MAX_ENTRIES];
    lvda_pkg::lvda_word_t data_tab [MAX_ENTRIES];
    logic                 irq_tab  [MAX_ENTRIES]; // intc after the entry
    int                   n_entries;
    int                   check_count;
    int                   error_count;
    int                   timeout_count;
    int                   idx;

    lvda u_dut (
        .sim_clk    (sim_clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd_addr   (cmd_addr),
        .cmd_data   (cmd_data),
        .discrete   (discrete),
        .data_out   (data_out),
        .data_frame (data_frame),
        .intc       (intc)
    );

    always #5 sim_clk = ~sim_clk;

    task automatic add_entry(input op_e op, input lvda_pkg::lvda_addr_t addr,
                             input lvda_pkg::lvda_word_t data, input logic irq);
        op_tab[n_entries]   = op;
        addr_tab[n_entries] = addr;
        data_tab[n_entries] = data;
        irq_tab[n_entries]  = irq;
        n_entries++;
    endtask

    task automatic check_word(input string name, input lvda_pkg::lvda_word_t got,
                              input lvda_pkg::lvda_word_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Discretes on top, then intc, then a bit that makes the ones count odd
    function automatic lvda_pkg::lvda_word_t expected_word(input lvda_pkg::lvda_discrete_t disc,
                                                           input logic irq);
        int ones;
        int i;
        lvda_pkg::lvda_word_t w;
        ones = irq;
        for (i = 0; i < lvda_pkg::DISCRETE_BITS; i++) begin
            ones += disc[i];
        end
        w = {disc, irq, 1'b0};
        if (ones % 2 == 0) w[0] = 1'b1;
        return w;
    endfunction

    task automatic send_command(input lvda_pkg::lvda_addr_t addr, input lvda_pkg::lvda_word_t data);
        int waited;
        waited    = 0;
        cmd_valid = 1'b1;
        cmd_addr  = addr;
        cmd_data  = data;
        while (!cmd_ready && waited < 4 * WORD_CYCLES) begin
            @(negedge sim_clk);
            waited++;
        end
        if (!cmd_ready) begin
            $display("timeout: command to address %h was never accepted", addr);
            timeout_count++;
        end
        @(negedge sim_clk); // Transfer on the rising edge in between
        cmd_valid = 1'b0;
    endtask

    task automatic capture_word(output lvda_pkg::lvda_word_t word, output logic ok);
        int waited;
        int cyc;
        word   = '0;
        ok     = 1'b0;
        waited = 0;
        while (!data_frame && waited < 2 * WORD_CYCLES + 8) begin
            @(negedge sim_clk);
            waited++;
        end
        if (!data_frame) begin
            $display("timeout: data_frame never rose");
            timeout_count++;
            return;
        end
        cyc = 0;
        while (data_frame && cyc < WORD_CYCLES + 8) begin
            if (cyc % 4 == 1) word = {word[lvda_pkg::WORD_BITS-2:0], data_out}; // Mid bit time
            @(negedge sim_clk);
            cyc++;
        end
        if (data_frame) begin
            $display("timeout: data_frame stayed high");
            timeout_count++;
            return;
        end
        if (cyc != WORD_CYCLES) begin
            $display("data_frame lasted %0d cycles instead of %0d", cyc, WORD_CYCLES);
            error_count++;
        end
        ok = 1'b1;
    endtask

    task automatic read_once(input lvda_pkg::lvda_addr_t addr,
                             input lvda_pkg::lvda_discrete_t disc, input logic irq);
        lvda_pkg::lvda_word_t got;
        logic                 ok;
        discrete = disc;
        send_command(addr, '0);
        capture_word(got, ok);
        if (ok) check_word("data_out", got, expected_word(disc, irq));
        check_flag("intc", intc, irq);
    endtask

    task automatic read_pair(input lvda_pkg::lvda_addr_t addr,
                             input lvda_pkg::lvda_discrete_t first, input logic irq);
        lvda_pkg::lvda_discrete_t second;
        lvda_pkg::lvda_word_t     got_a;
        lvda_pkg::lvda_word_t     got_b;
        logic                     ok_a;
        logic                     ok_b;
        logic                     frame_done;
        second     = lvda_pkg::lvda_discrete_t'($urandom);
        frame_done = 1'b0;
        discrete   = first;
        send_command(addr, '0);
        fork
            begin
                capture_word(got_a, ok_a);
                frame_done = 1'b1;
                discrete   = second;
                capture_word(got_b, ok_b);
            end
            begin
                send_command(addr, '0); // Held valid through the first frame
                if (!frame_done) begin
                    $display("second command was taken before the first frame ended");
                    error_count++;
                end
            end
        join
        if (ok_a) check_word("data_out", got_a, expected_word(first, irq));
        if (ok_b) check_word("data_out", got_b, expected_word(second, irq));
    endtask

    task automatic load_count(input lvda_pkg::lvda_addr_t addr,
                              input lvda_pkg::lvda_word_t data, input logic irq);
        int   waited;
        int   limit;
        logic rose;
        waited = 0;
        rose   = 1'b0;
        limit  = (int'(data[lvda_pkg::COUNT_BITS-1:0]) + 1) * WORD_CYCLES;
        send_command(addr, data);
        if (irq) begin
            while (!intc && waited < limit) begin
                @(negedge sim_clk);
                waited++;
            end
            if (!intc) begin
                $display("timeout: intc did not rise within %0d cycles", limit);
                timeout_count++;
            end
        end else begin
            repeat (2 * WORD_CYCLES) begin
                @(negedge sim_clk);
                if (intc) rose = 1'b1;
            end
            check_flag("intc rise", rose, 1'b0);
        end
        check_flag("intc", intc, irq);
    endtask

    task automatic clear_interrupt(input lvda_pkg::lvda_addr_t addr, input logic irq);
        send_command(addr, '0);
        @(negedge sim_clk); // Cleared one cycle after the strobe
        check_flag("intc", intc, irq);
    endtask

    task automatic unknown_command(input lvda_pkg::lvda_addr_t addr, input logic irq);
        logic framed;
        framed = 1'b0;
        send_command(addr, lvda_pkg::lvda_word_t'(1)); // Would expire fast if taken as a load
        repeat (2 * WORD_CYCLES) begin
            @(negedge sim_clk);
            if (data_frame) framed = 1'b1;
        end
        check_flag("data_frame", framed, 1'b0);
        check_flag("intc", intc, irq);
    endtask

    // Computer must be held off for the whole frame
    always @(negedge sim_clk) begin
        if (rst_n === 1'b1 && data_frame === 1'b1) check_flag("cmd_ready", cmd_ready, 1'b0);
    end

    initial begin
        void'($urandom(32'hd732));
        sim_clk       = 1'b0;
        rst_n         = 1'b0;
        cmd_valid     = 1'b0;
        cmd_addr      = '0;
        cmd_data      = '0;
        discrete      = '0;
        n_entries     = 0;
        check_count   = 0;
        error_count   = 0;
        timeout_count = 0;

        add_entry(OP_READ, lvda_pkg::ADDR_DISCRETE_READ, 26'h0000000, 1'b0);
        add_entry(OP_READ, lvda_pkg::ADDR_DISCRETE_READ, 26'h0FFFFFF, 1'b0);
        add_entry(OP_READ, lvda_pkg::ADDR_DISCRETE_READ, 26'h0A5C30F, 1'b0);
        add_entry(OP_RAND_READ, lvda_pkg::ADDR_DISCRETE_READ, 26'h0, 1'b0);
        add_entry(OP_RAND_READ, lvda_pkg::ADDR_DISCRETE_READ, 26'h0, 1'b0);
        add_entry(OP_PAIR, lvda_pkg::ADDR_DISCRETE_READ, 26'h0123456, 1'b0);
        add_entry(OP_OTHER, 9'h141, 26'h0, 1'b0);
        add_entry(OP_LOAD, lvda_pkg::ADDR_COUNT_LOAD, 26'h0000001, 1'b1);
        add_entry(OP_READ, lvda_pkg::ADDR_DISCRETE_READ, 26'h05A5A5A, 1'b1);
        add_entry(OP_OTHER, 9'h000, 26'h0, 1'b1);
        add_entry(OP_CLEAR, lvda_pkg::ADDR_INT_RESET, 26'h0, 1'b0);
        add_entry(OP_LOAD, lvda_pkg::ADDR_COUNT_LOAD, 26'h0000000, 1'b0);
        add_entry(OP_LOAD, lvda_pkg::ADDR_COUNT_LOAD, 26'h0000003, 1'b1);
        add_entry(OP_RAND_READ, lvda_pkg::ADDR_DISCRETE_READ, 26'h0, 1'b1);
        add_entry(OP_CLEAR, lvda_pkg::ADDR_INT_RESET, 26'h0, 1'b0);
        add_entry(OP_LOAD, lvda_pkg::ADDR_COUNT_LOAD, 26'h3FFF002, 1'b1); // Upper bits ignored
        add_entry(OP_CLEAR, lvda_pkg::ADDR_INT_RESET, 26'h0, 1'b0);
        add_entry(OP_OTHER, 9'h0C3, 26'h0, 1'b0);
        add_entry(OP_READ, lvda_pkg::ADDR_DISCRETE_READ, 26'h0800001, 1'b0);

        repeat (5) @(negedge sim_clk);
        rst_n = 1'b1;
        @(negedge sim_clk);
        check_flag("cmd_ready", cmd_ready, 1'b1);
        check_flag("data_frame", data_frame, 1'b0);
        check_flag("data_out", data_out, 1'b0);
        check_flag("intc", intc, 1'b0);

        for (idx = 0; idx < n_entries; idx++) begin
            case (op_tab[idx])
                OP_READ:
                    read_once(addr_tab[idx], data_tab[idx][lvda_pkg::DISCRETE_BITS-1:0],
                              irq_tab[idx]);
                OP_RAND_READ:
                    read_once(addr_tab[idx], lvda_pkg::lvda_discrete_t'($urandom), irq_tab[idx]);
                OP_PAIR:
                    read_pair(addr_tab[idx], data_tab[idx][lvda_pkg::DISCRETE_BITS-1:0],
                              irq_tab[idx]);
                OP_LOAD:  load_count(addr_tab[idx], data_tab[idx], irq_tab[idx]);
                OP_CLEAR: clear_interrupt(addr_tab[idx], irq_tab[idx]);
                default:  unknown_command(addr_tab[idx], irq_tab[idx]);
            endcase
        end

        $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/lvda.sv ====
`default_nettype none

module lvda (
    input  logic                     sim_clk,
    input  logic                     rst_n,
    input  logic                     cmd_valid,
    output logic                     cmd_ready,
    input  lvda_pkg::lvda_addr_t     cmd_addr,
    input  lvda_pkg::lvda_word_t     cmd_data,
    input  lvda_pkg::lvda_discrete_t discrete,
    output logic                     data_out,
    output logic                     data_frame,
    output logic                     intc
);

    lvda_pkg::lvda_phase_e phase;
    logic                  word_start;
    logic                  busy;
    logic                  read_req;
    logic                  load_req;
    logic                  int_clr_req;
    lvda_pkg::lvda_count_t load_value;

    lvda_timing u_timing (
        .sim_clk    (sim_clk),
        .rst_n      (rst_n),
        .phase      (phase),
        .word_start (word_start)
    );

    lvda_cmd_decode u_decode (
        .sim_clk     (sim_clk),
        .rst_n       (rst_n),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .cmd_addr    (cmd_addr),
        .cmd_data    (cmd_data),
        .busy        (busy),
        .read_req    (read_req),
        .load_req    (load_req),
        .int_clr_req (int_clr_req),
        .load_value  (load_value)
    );

    lvda_discrete_sampler u_sampler (
        .sim_clk    (sim_clk),
        .rst_n      (rst_n),
        .discrete   (discrete),
        .phase      (phase),
        .word_start (word_start),
        .read_req   (read_req),
        .intc       (intc),        // Sent in bit 1
        .busy       (busy),
        .data_out   (data_out),
        .data_frame (data_frame)
    );

    lvda_countdown u_countdown (
        .sim_clk     (sim_clk),
        .rst_n       (rst_n),
        .word_start  (word_start),
        .load_req    (load_req),
        .load_value  (load_value),
        .int_clr_req (int_clr_req),
        .intc        (intc)
    );

endmodule

`default_nettype wire

// ==== verilog/lvda_cmd_decode.sv ====
`default_nettype none

module lvda_cmd_decode (
    input  logic                  sim_clk,
    input  logic                  rst_n,
    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    input  lvda_pkg::lvda_addr_t  cmd_addr,
    input  lvda_pkg::lvda_word_t  cmd_data,
    input  logic                  busy,
    output logic                  read_req,
    output logic                  load_req,
    output logic                  int_clr_req,
    output lvda_pkg::lvda_count_t load_value
);

    logic xfer;
    logic hit_read;
    logic hit_load;
    logic hit_clr;

    // Hold off the computer while a read is pending or on the line
    assign cmd_ready = !busy;
    assign xfer      = cmd_valid && cmd_ready;

    assign hit_read = (cmd_addr == lvda_pkg::ADDR_DISCRETE_READ);
    assign hit_load = (cmd_addr == lvda_pkg::ADDR_COUNT_LOAD);
    assign hit_clr  = (cmd_addr == lvda_pkg::ADDR_INT_RESET);

    // One-cycle strobes and none for unknown addresses
    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            read_req    <= 1'b0;
            load_req    <= 1'b0;
            int_clr_req <= 1'b0;
        end else begin
            read_req    <= xfer && hit_read;
            load_req    <= xfer && hit_load;
            int_clr_req <= xfer && hit_clr;
        end
    end

    // Count value rides along with load_req
    always_ff @(posedge sim_clk) begin
        if (xfer && hit_load) begin
            load_value <= cmd_data[lvda_pkg::COUNT_BITS-1:0];
        end
    end

    a_one_strobe: assert property (
        @(posedge sim_clk) disable iff (!rst_n)
        $onehot0({read_req, load_req, int_clr_req})
    ) else $error("more than one command strobe");

endmodule

`default_nettype wire

// ==== verilog/lvda_countdown.sv ====
`default_nettype none

module lvda_countdown (
    input  logic                  sim_clk,
    input  logic                  rst_n,
    input  logic                  word_start,
    input  logic                  load_req,
    input  lvda_pkg::lvda_count_t load_value,
    input  logic                  int_clr_req,
    output logic                  intc
);

    lvda_pkg::lvda_count_t count;
    logic                  dec;
    logic                  hit_zero;

    // Decrement a nonzero count once per word unless loading
    assign dec      = word_start && !load_req && (count != '0);
    assign hit_zero = dec && (count == lvda_pkg::lvda_count_t'(1));

    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (load_req) begin
            count <= load_value;
        end else if (dec) begin
            count <= count - 1'b1;
        end
    end

    // Interrupt latch where a new expiry wins over a clear
    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            intc <= 1'b0;
        end else if (hit_zero) begin
            intc <= 1'b1;
        end else if (int_clr_req) begin
            intc <= 1'b0;
        end
    end

    a_no_wrap: assert property (
        @(posedge sim_clk) disable iff (!rst_n)
        (word_start && !load_req && count == '0) |=> count == '0
    ) else $error("countdown wrapped from zero");

endmodule

`default_nettype wire

// ==== verilog/lvda_discrete_sampler.sv ====
`default_nettype none

module lvda_discrete_sampler (
    input  logic                     sim_clk,
    input  logic                     rst_n,
    input  lvda_pkg::lvda_discrete_t discrete,
    input  lvda_pkg::lvda_phase_e    phase,
    input  logic                     word_start,
    input  logic                     read_req,
    input  logic                     intc,
    output logic                     busy,
    output logic                     data_out,
    output logic                     data_frame
);

    lvda_pkg::lvda_discrete_t    disc_meta;
    lvda_pkg::lvda_discrete_t    disc_sync;
    lvda_pkg::lvda_word_t        word_next;
    lvda_pkg::lvda_word_t        shift_reg;
    lvda_pkg::lvda_shift_state_e state;

    // Two-flop synchronizer for the asynchronous discretes
    always_ff @(posedge sim_clk) begin
        disc_meta <= discrete;
        disc_sync <= disc_meta;
    end

    // Discretes, interrupt, then odd parity
    assign word_next = {disc_sync, intc, ~(^{disc_sync, intc})};

    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= lvda_pkg::SHIFT_IDLE;
        end else begin
            unique case (state)
                lvda_pkg::SHIFT_IDLE: if (read_req) state <= lvda_pkg::SHIFT_WAIT;
                lvda_pkg::SHIFT_WAIT: if (word_start) state <= lvda_pkg::SHIFT_SEND;
                lvda_pkg::SHIFT_SEND: if (word_start) state <= lvda_pkg::SHIFT_IDLE;
                default:              state <= lvda_pkg::SHIFT_IDLE;
            endcase
        end
    end

    // Load at the word boundary, shift MSB first on each later W phase
    always_ff @(posedge sim_clk) begin
        if (state == lvda_pkg::SHIFT_WAIT && word_start) begin
            shift_reg <= word_next;
        end else if (state == lvda_pkg::SHIFT_SEND && phase == lvda_pkg::PHASE_W) begin
            shift_reg <= {shift_reg[lvda_pkg::WORD_BITS-2:0], 1'b0};
        end
    end

    assign data_frame = (state == lvda_pkg::SHIFT_SEND);
    assign data_out   = data_frame && shift_reg[lvda_pkg::WORD_BITS-1];
    assign busy       = read_req || (state != lvda_pkg::SHIFT_IDLE); // Same cycle as read_req

    // Decoder must hold reads off until the frame is done
    a_no_read_busy: assert property (
        @(posedge sim_clk) disable iff (!rst_n)
        read_req |-> state == lvda_pkg::SHIFT_IDLE
    ) else $error("read_req while sampler busy");

endmodule

`default_nettype wire

// ==== verilog/lvda_pkg.sv ====
`default_nettype none

package lvda_pkg;

    // Widths
    localparam int WORD_BITS     = 26; // Serial word
    localparam int DISCRETE_BITS = 24;
    localparam int COUNT_BITS    = 12;
    localparam int ADDR_BITS     = 9;

    typedef logic [WORD_BITS-1:0]     lvda_word_t;
    typedef logic [DISCRETE_BITS-1:0] lvda_discrete_t;
    typedef logic [COUNT_BITS-1:0]    lvda_count_t;
    typedef logic [ADDR_BITS-1:0]     lvda_addr_t;
    typedef logic [4:0]               lvda_bit_idx_t; // 0 to 25

    // Four clock phases per bit time
    typedef enum logic [1:0] {
        PHASE_W,
        PHASE_X,
        PHASE_Y,
        PHASE_Z
    } lvda_phase_e;

    typedef enum logic [1:0] {
        SHIFT_IDLE,
        SHIFT_WAIT,
        SHIFT_SEND
    } lvda_shift_state_e;

    // Command addresses
    localparam lvda_addr_t ADDR_DISCRETE_READ = 9'h041;
    localparam lvda_addr_t ADDR_COUNT_LOAD    = 9'h0C2;
    localparam lvda_addr_t ADDR_INT_RESET     = 9'h104;

endpackage

`default_nettype wire

// ==== verilog/lvda_timing.sv ====
`default_nettype none

module lvda_timing (
    input  logic                  sim_clk,
    input  logic                  rst_n,
    output lvda_pkg::lvda_phase_e phase,
    output logic                  word_start
);

    lvda_pkg::lvda_bit_idx_t bit_idx;

    // Free-running phase W X Y Z
    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= lvda_pkg::PHASE_W;
        end else begin
            phase <= lvda_pkg::lvda_phase_e'(phase + 2'd1);
        end
    end

    // Bit time advances after phase Z
    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_idx <= '0;
        end else if (phase == lvda_pkg::PHASE_Z) begin
            if (bit_idx == lvda_pkg::lvda_bit_idx_t'(lvda_pkg::WORD_BITS - 1)) begin
                bit_idx <= '0;
            end else begin
                bit_idx <= bit_idx + 5'd1;
            end
        end
    end

    // Phase W of bit 0
    assign word_start = (bit_idx == '0) && (phase == lvda_pkg::PHASE_W);

    a_bit_idx_range: assert property (
        @(posedge sim_clk) disable iff (!rst_n)
        bit_idx <= lvda_pkg::lvda_bit_idx_t'(lvda_pkg::WORD_BITS - 1)
    ) else $error("bit index out of range");

endmodule

`default_nettype wire
